/* flist.f */
verilog/sb_pkg.sv
verilog/sb_entry_store.sv
verilog/sb_clobber_map.sv
verilog/sb_operand_fwd.sv
verilog/scoreboard_top.sv
verification/scoreboard_assert.sv
verification/tb_scoreboard.sv

/* run_sim.sh */
#!/bin/sh
# build and run the scoreboard testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_scoreboard \
  --Mdir obj_dir -o sim_scoreboard \
  -f flist.f

./obj_dir/sim_scoreboard

/* verification/scoreboard_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard_assert #(
  parameter int unsigned NR_WB_PORTS     = 2,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input logic                                    clk_i,
  input logic                                    rst_ni,
  input logic                                    issue_instr_valid_o,
  input logic                                    decoded_instr_ack_o,
  input sb_pkg::wb_port_t  [NR_WB_PORTS-1:0]     wb_i,
  input sb_pkg::sb_instr_t [NR_COMMIT_PORTS-1:0] commit_instr_o,
  input logic [NR_COMMIT_PORTS-1:0]              commit_ack_i,
  input sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]       rd_clobber_o
);

  // acked instruction must have been issuable
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    decoded_instr_ack_o |-> issue_instr_valid_o)
    else $error("issue ack without a valid issue instruction");

  // x0 never has a pending writer
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_clobber_o[0] == sb_pkg::FU_NONE)
    else $error("register x0 shows a clobber");

  // --------------------
  // per port checks
  // --------------------
  for (genvar k = 0; k < NR_COMMIT_PORTS; k++) begin : gen_commit
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      commit_ack_i[k] |-> commit_instr_o[k].valid)
      else $error("commit ack on port %0d without a valid entry", k);
  end

  // each result targets its own entry
  for (genvar i = 0; i < NR_WB_PORTS; i++) begin : gen_wb_a
    for (genvar j = i + 1; j < NR_WB_PORTS; j++) begin : gen_wb_b
      assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(wb_i[i].valid && wb_i[j].valid && (wb_i[i].trans_id == wb_i[j].trans_id)))
        else $error("write-back ports %0d and %0d share a trans_id", i, j);
    end
  end

endmodule

bind scoreboard_top scoreboard_assert #(
  .NR_WB_PORTS     (NR_WB_PORTS),
  .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
) i_scoreboard_assert (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .issue_instr_valid_o (issue_instr_valid_o),
  .decoded_instr_ack_o (decoded_instr_ack_o),
  .wb_i                (wb_i),
  .commit_instr_o      (commit_instr_o),
  .commit_ack_i        (commit_ack_i),
  .rd_clobber_o        (rd_clobber_o)
);

`default_nettype wire

/* verification/tb_scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard;

  localparam int unsigned NR_WB          = 2;
  localparam int unsigned NR_COMMIT      = 2;
  // well above the cycles the tests need
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  logic                                  clk_i;
  logic                                  rst_ni;
  sb_pkg::sb_instr_t                     decoded_instr_i;
  logic                                  decoded_instr_valid_i;
  logic                                  issue_ack_i;
  logic                                  unresolved_branch_i;
  sb_pkg::sb_instr_t                     issue_instr_o;
  logic                                  issue_instr_valid_o;
  logic                                  decoded_instr_ack_o;
  logic                                  sb_full_o;
  sb_pkg::wb_port_t  [NR_WB-1:0]         wb_i;
  sb_pkg::sb_instr_t [NR_COMMIT-1:0]     commit_instr_o;
  logic [NR_COMMIT-1:0]                  commit_ack_i;
  logic                                  flush_i;
  logic                                  flush_unissued_i;
  sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]     rd_clobber_o;
  sb_pkg::reg_addr_t                     rs1_i;
  sb_pkg::reg_addr_t                     rs2_i;
  sb_pkg::xlen_t                         rs1_o;
  sb_pkg::xlen_t                         rs2_o;
  logic                                  rs1_valid_o;
  logic                                  rs2_valid_o;

  // reference model, oldest in-flight instruction at the front
  sb_pkg::sb_instr_t model_q[$];
  sb_pkg::fu_t       exp_clobber [sb_pkg::NR_REGS];
  int unsigned       next_id = 0;
  int unsigned       cycles  = 0;
  int                seed;
  string             test_name = "reset";

  scoreboard_top #(
    .NR_WB_PORTS     (NR_WB),
    .NR_COMMIT_PORTS (NR_COMMIT)
  ) i_scoreboard_top (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .issue_ack_i           (issue_ack_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .wb_i                  (wb_i),
    .commit_instr_o        (commit_instr_o),
    .commit_ack_i          (commit_ack_i),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .rd_clobber_o          (rd_clobber_o),
    .rs1_i                 (rs1_i),
    .rs2_i                 (rs2_i),
    .rs1_o                 (rs1_o),
    .rs2_o                 (rs2_o),
    .rs1_valid_o           (rs1_valid_o),
    .rs2_valid_o           (rs2_valid_o)
  );

  // --------------------
  // clock and watchdog
  // --------------------
  initial clk_i = 1'b0;
  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // --------------------
  // helpers
  // --------------------
  task automatic check(input string what, input logic [31:0] exp_val,
                       input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp_val, act_val);
      $display("SOME TESTS FAILED");
      $fatal(1, "mismatch in test %s", test_name);
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic tick();
    @(posedge clk_i);
    #1;
  endtask

  task automatic clear_inputs();
    decoded_instr_i       = '0;
    decoded_instr_valid_i = 1'b0;
    issue_ack_i           = 1'b0;
    unresolved_branch_i   = 1'b0;
    wb_i                  = '0;
    commit_ack_i          = '0;
    flush_i               = 1'b0;
    flush_unissued_i      = 1'b0;
  endtask

  task automatic offer(input sb_pkg::fu_t fu, input sb_pkg::reg_addr_t rd);
    decoded_instr_i       = '0;
    decoded_instr_i.pc    = $random(seed);
    decoded_instr_i.fu    = fu;
    decoded_instr_i.rd    = rd;
    decoded_instr_valid_i = 1'b1;
    issue_ack_i           = 1'b1;
  endtask

  // one accepted instruction, trans_id follows the issue order modulo the depth
  task automatic issue(input sb_pkg::fu_t fu, input sb_pkg::reg_addr_t rd);
    sb_pkg::sb_instr_t rec;
    offer(fu, rd);
    #10;
    check("issue ack", 32'(1'b1), 32'(decoded_instr_ack_o));
    check("issue trans_id", next_id, 32'(issue_instr_o.trans_id));
    rec          = decoded_instr_i;
    rec.trans_id = sb_pkg::trans_id_t'(next_id);
    model_q.push_back(rec);
    next_id = (next_id + 1) % sb_pkg::SB_DEPTH;
    tick();
    clear_inputs();
  endtask

  // qi is the position in the model queue
  task automatic write_back(input int port, input int qi, input logic ex);
    sb_pkg::xlen_t data;
    data                 = $random(seed);
    wb_i[port].valid     = 1'b1;
    wb_i[port].trans_id  = model_q[qi].trans_id;
    wb_i[port].data      = data;
    wb_i[port].ex_valid  = ex;
    model_q[qi].result   = data;
    model_q[qi].ex_valid = ex;
  endtask

  // ports show the oldest entries in issue order
  task automatic commit(input int n);
    sb_pkg::sb_instr_t exp_rec;
    for (int k = 0; k < n; k++) begin
      exp_rec = model_q[k];
      check("commit valid", 32'(1'b1), 32'(commit_instr_o[k].valid));
      check("commit pc", exp_rec.pc, commit_instr_o[k].pc);
      check("commit fu", 32'(exp_rec.fu), 32'(commit_instr_o[k].fu));
      check("commit rd", 32'(exp_rec.rd), 32'(commit_instr_o[k].rd));
      check("commit trans_id", 32'(exp_rec.trans_id), 32'(commit_instr_o[k].trans_id));
      check("commit result", exp_rec.result, commit_instr_o[k].result);
      check("commit ex_valid", 32'(exp_rec.ex_valid), 32'(commit_instr_o[k].ex_valid));
      commit_ack_i[k] = 1'b1;
    end
    tick();
    commit_ack_i = '0;
    for (int k = 0; k < n; k++) begin
      exp_rec = model_q.pop_front();
    end
  endtask

  task automatic clobbers_free();
    for (int r = 0; r < sb_pkg::NR_REGS; r++) begin
      exp_clobber[r] = sb_pkg::FU_NONE;
    end
  endtask

  task automatic compare_clobbers();
    for (int r = 0; r < sb_pkg::NR_REGS; r++) begin
      check($sformatf("clobber x%0d", r), 32'(exp_clobber[r]), 32'(rd_clobber_o[r]));
    end
  endtask

  // --------------------
  // tests
  // --------------------
  task automatic test_issue_full();
    test_name = "issue_full";
    for (int i = 0; i < 8; i++) begin
      issue(sb_pkg::FU_ALU, sb_pkg::reg_addr_t'(i + 1));
    end
    check("full", 32'(1'b1), 32'(sb_full_o));
    // offered while full, must be neither acked nor stored
    offer(sb_pkg::FU_ALU, 5'd20);
    #10;
    check("ack while full", 32'(1'b0), 32'(decoded_instr_ack_o));
    check("issue valid while full", 32'(1'b0), 32'(issue_instr_valid_o));
    tick();
    clear_inputs();
    check("still full", 32'(1'b1), 32'(sb_full_o));
    write_back(0, 0, 1'b0);
    tick();
    clear_inputs();
    commit(1);
    // freed slot 0 is reused
    issue(sb_pkg::FU_ALU, 5'd21);
  endtask

  task automatic test_out_of_order();
    test_name = "out_of_order";
    for (int i = 7; i >= 1; i -= 2) begin
      write_back(0, i, 1'b0);
      write_back(1, i - 1, 1'b0);
      check("valid before wb edge", 32'(1'b0), 32'(commit_instr_o[0].valid));
      tick();
      clear_inputs();
    end
    for (int i = 0; i < 4; i++) begin
      commit(2);
    end
  endtask

  task automatic test_clobber();
    test_name = "clobber";
    issue(sb_pkg::FU_ALU, 5'd3);
    issue(sb_pkg::FU_LOAD, 5'd7);
    issue(sb_pkg::FU_ALU, 5'd0);
    clobbers_free();
    exp_clobber[3] = sb_pkg::FU_ALU;
    exp_clobber[7] = sb_pkg::FU_LOAD;
    compare_clobbers();
    write_back(0, 0, 1'b0);
    write_back(1, 1, 1'b0);
    tick();
    clear_inputs();
    write_back(0, 2, 1'b0);
    tick();
    clear_inputs();
    commit(2);
    commit(1);
    clobbers_free();
    compare_clobbers();
  endtask

  task automatic test_forwarding();
    test_name = "forwarding";
    issue(sb_pkg::FU_ALU, 5'd9);
    issue(sb_pkg::FU_ALU, 5'd10);
    rs1_i = 5'd9;
    rs2_i = 5'd10;
    write_back(0, 0, 1'b0);
    // faulting result on the other port
    write_back(1, 1, 1'b1);
    #10;
    check("rs1 valid from port", 32'(1'b1), 32'(rs1_valid_o));
    check("rs1 data from port", model_q[0].result, rs1_o);
    check("rs2 valid with ex", 32'(1'b0), 32'(rs2_valid_o));
    tick();
    clear_inputs();
    rs2_i = 5'd0;
    #10;
    check("rs1 valid from entry", 32'(1'b1), 32'(rs1_valid_o));
    check("rs1 data from entry", model_q[0].result, rs1_o);
    check("rs2 valid for x0", 32'(1'b0), 32'(rs2_valid_o));
    tick();
    // second read port on the completed entry
    rs2_i = 5'd9;
    #10;
    check("rs2 valid from entry", 32'(1'b1), 32'(rs2_valid_o));
    check("rs2 data from entry", model_q[0].result, rs2_o);
    tick();
    rs1_i = 5'd0;
    rs2_i = 5'd0;
    commit(2);
  endtask

  task automatic test_fu_none_ex();
    test_name = "fu_none_ex";
    issue(sb_pkg::FU_NONE, 5'd5);
    check("fu_none valid after 1 cycle", 32'(1'b0), 32'(commit_instr_o[0].valid));
    tick();
    check("fu_none valid after 2 cycles", 32'(1'b1), 32'(commit_instr_o[0].valid));
    issue(sb_pkg::FU_ALU, 5'd6);
    write_back(0, 1, 1'b1);
    tick();
    clear_inputs();
    commit(2);
  endtask

  task automatic test_flush();
    test_name = "flush";
    offer(sb_pkg::FU_ALU, 5'd11);
    flush_unissued_i = 1'b1;
    tick();
    clear_inputs();
    // dropped instruction used no trans_id
    issue(sb_pkg::FU_ALU, 5'd12);
    issue(sb_pkg::FU_LOAD, 5'd13);
    // fill the remaining slots and complete the two oldest
    for (int i = 0; i < 6; i++) begin
      issue(sb_pkg::FU_MULT, sb_pkg::reg_addr_t'(i + 14));
    end
    write_back(0, 0, 1'b0);
    write_back(1, 1, 1'b1);
    tick();
    clear_inputs();
    check("full before flush", 32'(1'b1), 32'(sb_full_o));
    check("commit 0 valid before flush", 32'(1'b1), 32'(commit_instr_o[0].valid));
    check("commit 1 valid before flush", 32'(1'b1), 32'(commit_instr_o[1].valid));
    flush_i = 1'b1;
    tick();
    clear_inputs();
    model_q.delete();
    next_id = 0;
    check("commit 0 valid after flush", 32'(1'b0), 32'(commit_instr_o[0].valid));
    check("commit 1 valid after flush", 32'(1'b0), 32'(commit_instr_o[1].valid));
    check("full after flush", 32'(1'b0), 32'(sb_full_o));
    clobbers_free();
    compare_clobbers();
    issue(sb_pkg::FU_ALU, 5'd14);
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    seed   = 32'h6a03fd99;
    rst_ni = 1'b0;
    rs1_i  = '0;
    rs2_i  = '0;
    clear_inputs();
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    check("full after reset", 32'(1'b0), 32'(sb_full_o));
    check("commit 0 after reset", 32'(1'b0), 32'(commit_instr_o[0].valid));
    check("commit 1 after reset", 32'(1'b0), 32'(commit_instr_o[1].valid));
    check("rs1 valid after reset", 32'(1'b0), 32'(rs1_valid_o));
    check("rs2 valid after reset", 32'(1'b0), 32'(rs2_valid_o));
    clobbers_free();
    compare_clobbers();
    test_issue_full();
    test_out_of_order();
    test_clobber();
    test_forwarding();
    test_fu_none_ex();
    test_flush();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/sb_clobber_map.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_clobber_map (
  input  sb_pkg::sb_slot_t [sb_pkg::SB_DEPTH-1:0] slots_i,
  // unit that will write each register, FU_NONE when free
  output sb_pkg::fu_t      [sb_pkg::NR_REGS-1:0]  rd_clobber_o
);

  for (genvar r = 0; r < sb_pkg::NR_REGS; r++) begin : gen_reg
    if (r == 0) begin : gen_x0
      // x0 is never written
      assign rd_clobber_o[r] = sb_pkg::FU_NONE;
    end else begin : gen_xr
      logic [sb_pkg::SB_DEPTH-1:0] hit;
      sb_pkg::fu_t                 sel;

      // --------------------
      // match per entry
      // --------------------
      always_comb begin
        for (int unsigned i = 0; i < sb_pkg::SB_DEPTH; i++) begin
          hit[i] = slots_i[i].issued &&
                   (slots_i[i].instr.rd == sb_pkg::reg_addr_t'(r));
        end
      end

      // fixed priority, scan downwards so the lowest index is taken last
      // normally at most one in-flight entry targets a register
      always_comb begin
        sel = sb_pkg::FU_NONE;
        for (int i = sb_pkg::SB_DEPTH - 1; i >= 0; i--) begin
          if (hit[i]) begin
            sel = slots_i[i].instr.fu;
          end
        end
      end

      assign rd_clobber_o[r] = sel;
    end
  end

endmodule

`default_nettype wire

/* verilog/sb_entry_store.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_entry_store #(
  parameter int unsigned NR_WB_PORTS     = 2,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  input  logic                                     flush_i,
  input  logic                                     flush_unissued_i,
  input  logic                                     unresolved_branch_i,
  // decode side
  input  sb_pkg::sb_instr_t                        decoded_instr_i,
  input  logic                                     decoded_instr_valid_i,
  input  logic                                     issue_ack_i,
  // functional unit results
  input  sb_pkg::wb_port_t [NR_WB_PORTS-1:0]       wb_i,
  // commit stage acknowledges
  input  logic [NR_COMMIT_PORTS-1:0]               commit_ack_i,
  output sb_pkg::sb_instr_t                        issue_instr_o,
  output logic                                     issue_instr_valid_o,
  output logic                                     decoded_instr_ack_o,
  output logic                                     sb_full_o,
  output sb_pkg::sb_instr_t [NR_COMMIT_PORTS-1:0]  commit_instr_o,
  // registered entries for clobber map and forwarding
  output sb_pkg::sb_slot_t [sb_pkg::SB_DEPTH-1:0]  slots_o
);

  sb_pkg::sb_slot_t [sb_pkg::SB_DEPTH-1:0]   mem_q, mem_d;
  sb_pkg::trans_id_t                         issue_ptr_q, issue_ptr_d;
  sb_pkg::trans_id_t                         commit_ptr_q, commit_ptr_d;
  sb_pkg::sb_cnt_t                           cnt_q, cnt_d;
  sb_pkg::sb_cnt_t                           num_commit;
  sb_pkg::trans_id_t [NR_COMMIT_PORTS-1:0]   commit_idx;
  logic                                      full;
  logic                                      issue_en;

  // full once every slot holds an instruction
  assign full      = (cnt_q == sb_pkg::sb_cnt_t'(sb_pkg::SB_DEPTH));
  assign sb_full_o = full;
  assign slots_o   = mem_q;

  // --------------------
  // issue side
  // --------------------
  // offered instruction goes out with the slot it will occupy
  always_comb begin
    issue_instr_o          = decoded_instr_i;
    issue_instr_o.trans_id = issue_ptr_q;
  end

  assign issue_instr_valid_o = decoded_instr_valid_i & ~unresolved_branch_i & ~full;
  // no ack while full, the decoder keeps offering
  assign decoded_instr_ack_o = issue_ack_i & ~full;
  // an un-issued flush drops the acknowledged instruction
  assign issue_en = decoded_instr_valid_i & decoded_instr_ack_o & ~flush_unissued_i;

  // --------------------
  // commit side
  // --------------------
  // port k looks k entries past the commit pointer, wrapping around
  always_comb begin
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      commit_idx[k]              = commit_ptr_q + sb_pkg::trans_id_t'(k);
      commit_instr_o[k]          = mem_q[commit_idx[k]].instr;
      commit_instr_o[k].trans_id = commit_idx[k];
    end
  end

  // acks are in order, so their count is enough
  always_comb begin
    num_commit = '0;
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      num_commit = num_commit + sb_pkg::sb_cnt_t'(commit_ack_i[k]);
    end
  end

  // --------------------
  // entry update
  // --------------------
  // later steps override earlier ones, flush wins over everything
  always_comb begin
    mem_d = mem_q;

    // new instruction at the issue pointer
    if (issue_en) begin
      mem_d[issue_ptr_q].issued         = 1'b1;
      mem_d[issue_ptr_q].instr          = decoded_instr_i;
      mem_d[issue_ptr_q].instr.trans_id = issue_ptr_q;
    end

    // nothing to wait for, complete one cycle after being stored
    for (int unsigned i = 0; i < sb_pkg::SB_DEPTH; i++) begin
      if (mem_q[i].issued && (mem_q[i].instr.fu == sb_pkg::FU_NONE)) begin
        mem_d[i].instr.valid = 1'b1;
      end
    end

    // results, only for slots still in flight
    // a stale write-back after a flush lands on a free slot and is dropped
    for (int unsigned p = 0; p < NR_WB_PORTS; p++) begin
      if (wb_i[p].valid && mem_q[wb_i[p].trans_id].issued) begin
        mem_d[wb_i[p].trans_id].instr.valid  = 1'b1;
        mem_d[wb_i[p].trans_id].instr.result = wb_i[p].data;
        if (wb_i[p].ex_valid) begin
          mem_d[wb_i[p].trans_id].instr.ex_valid = 1'b1;
        end
      end
    end

    // retired entries leave the window
    for (int unsigned k = 0; k < NR_COMMIT_PORTS; k++) begin
      if (commit_ack_i[k]) begin
        mem_d[commit_idx[k]].issued      = 1'b0;
        mem_d[commit_idx[k]].instr.valid = 1'b0;
      end
    end

    // drop every flag, payload is left as is
    if (flush_i) begin
      for (int unsigned i = 0; i < sb_pkg::SB_DEPTH; i++) begin
        mem_d[i].issued         = 1'b0;
        mem_d[i].instr.valid    = 1'b0;
        mem_d[i].instr.ex_valid = 1'b0;
      end
    end
  end

  // pointers and occupancy
  assign issue_ptr_d  = flush_i ? '0 : issue_ptr_q + sb_pkg::trans_id_t'(issue_en);
  assign commit_ptr_d = flush_i ? '0 : commit_ptr_q + sb_pkg::trans_id_t'(num_commit);
  assign cnt_d        = flush_i ? '0 : cnt_q - num_commit + sb_pkg::sb_cnt_t'(issue_en);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q        <= '0;
      issue_ptr_q  <= '0;
      commit_ptr_q <= '0;
      cnt_q        <= '0;
    end else begin
      mem_q        <= mem_d;
      issue_ptr_q  <= issue_ptr_d;
      commit_ptr_q <= commit_ptr_d;
      cnt_q        <= cnt_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/sb_operand_fwd.sv */
`timescale 1ns/1ps
`default_nettype none

module sb_operand_fwd #(
  parameter int unsigned NR_WB_PORTS = 2
) (
  input  sb_pkg::sb_slot_t [sb_pkg::SB_DEPTH-1:0] slots_i,
  input  sb_pkg::wb_port_t [NR_WB_PORTS-1:0]      wb_i,
  input  sb_pkg::reg_addr_t                       rs1_i,
  input  sb_pkg::reg_addr_t                       rs2_i,
  output sb_pkg::xlen_t                           rs1_o,
  output sb_pkg::xlen_t                           rs2_o,
  output logic                                    rs1_valid_o,
  output logic                                    rs2_valid_o
);

  // selected operand and whether one was found
  typedef struct packed {
    logic          valid;
    sb_pkg::xlen_t data;
  } fwd_t;

  fwd_t rs1_fwd;
  fwd_t rs2_fwd;

  // --------------------
  // operand select
  // --------------------
  // lowest priority is checked first and overwritten by higher ones
  // order: entries high to low, then write-back ports high to low
  function automatic fwd_t fwd_select(
    input sb_pkg::reg_addr_t                       rs,
    input sb_pkg::sb_slot_t [sb_pkg::SB_DEPTH-1:0] slots,
    input sb_pkg::wb_port_t [NR_WB_PORTS-1:0]      wb
  );
    fwd_t res;
    res = '0;
    // completed entries still waiting for commit
    for (int i = sb_pkg::SB_DEPTH - 1; i >= 0; i--) begin
      if (slots[i].issued && slots[i].instr.valid && (slots[i].instr.rd == rs)) begin
        res.valid = 1'b1;
        res.data  = slots[i].instr.result;
      end
    end
    // results arriving this cycle, rd looked up in their entry
    // faulting results are never forwarded
    for (int k = NR_WB_PORTS - 1; k >= 0; k--) begin
      if (wb[k].valid && !wb[k].ex_valid && (slots[wb[k].trans_id].instr.rd == rs)) begin
        res.valid = 1'b1;
        res.data  = wb[k].data;
      end
    end
    // x0 always comes from the register file
    if (rs == '0) begin
      res.valid = 1'b0;
    end
    return res;
  endfunction

  // same select for both source registers
  assign rs1_fwd = fwd_select(rs1_i, slots_i, wb_i);
  assign rs2_fwd = fwd_select(rs2_i, slots_i, wb_i);

  assign rs1_o       = rs1_fwd.data;
  assign rs1_valid_o = rs1_fwd.valid;
  assign rs2_o       = rs2_fwd.data;
  assign rs2_valid_o = rs2_fwd.valid;

endmodule

`default_nettype wire

/* verilog/sb_pkg.sv */
`default_nettype none

package sb_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int unsigned REG_ADDR_BITS = 5;
  localparam int unsigned NR_REGS       = 32;
  localparam int unsigned XLEN          = 32;
  // number of scoreboard entries, must stay a power of two
  localparam int unsigned SB_DEPTH      = 8;
  localparam int unsigned TRANS_ID_BITS = 3;

  typedef logic [REG_ADDR_BITS-1:0] reg_addr_t;
  typedef logic [XLEN-1:0]          xlen_t;
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;
  // one extra bit so the count can reach SB_DEPTH
  typedef logic [TRANS_ID_BITS:0]   sb_cnt_t;

  // functional unit that produces the result of an instruction
  typedef enum logic [2:0] {
    FU_NONE   = 3'd0,
    FU_ALU    = 3'd1,
    FU_LOAD   = 3'd2,
    FU_STORE  = 3'd3,
    FU_BRANCH = 3'd4,
    FU_MULT   = 3'd5
  } fu_t;

  // --------------------
  // records
  // --------------------
  // one instruction as seen by issue and commit
  typedef struct packed {
    xlen_t     pc;
    fu_t       fu;
    reg_addr_t rd;
    xlen_t     result;
    // result is present
    logic      valid;
    logic      ex_valid;
    trans_id_t trans_id;
  } sb_instr_t;

  // result returned by a functional unit
  typedef struct packed {
    logic      valid;
    trans_id_t trans_id;
    xlen_t     data;
    logic      ex_valid;
  } wb_port_t;

  // stored entry, issued marks the slot as occupied
  typedef struct packed {
    logic      issued;
    sb_instr_t instr;
  } sb_slot_t;

endpackage

`default_nettype wire

/* verilog/scoreboard_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard_top #(
  parameter int unsigned NR_WB_PORTS     = 2,
  parameter int unsigned NR_COMMIT_PORTS = 2
) (
  input  logic                                     clk_i,
  input  logic                                     rst_ni,
  // decode side
  input  sb_pkg::sb_instr_t                        decoded_instr_i,
  input  logic                                     decoded_instr_valid_i,
  input  logic                                     issue_ack_i,
  input  logic                                     unresolved_branch_i,
  output sb_pkg::sb_instr_t                        issue_instr_o,
  output logic                                     issue_instr_valid_o,
  output logic                                     decoded_instr_ack_o,
  output logic                                     sb_full_o,
  // write-back side
  input  sb_pkg::wb_port_t [NR_WB_PORTS-1:0]       wb_i,
  // commit side
  output sb_pkg::sb_instr_t [NR_COMMIT_PORTS-1:0]  commit_instr_o,
  input  logic [NR_COMMIT_PORTS-1:0]               commit_ack_i,
  // flushes
  input  logic                                     flush_i,
  input  logic                                     flush_unissued_i,
  // clobber map
  output sb_pkg::fu_t [sb_pkg::NR_REGS-1:0]        rd_clobber_o,
  // operand read
  input  sb_pkg::reg_addr_t                        rs1_i,
  input  sb_pkg::reg_addr_t                        rs2_i,
  output sb_pkg::xlen_t                            rs1_o,
  output sb_pkg::xlen_t                            rs2_o,
  output logic                                     rs1_valid_o,
  output logic                                     rs2_valid_o
);

  // registered entries shared by the lookup blocks
  sb_pkg::sb_slot_t [sb_pkg::SB_DEPTH-1:0] slots;

  // --------------------
  // entry store
  // --------------------
  sb_entry_store #(
    .NR_WB_PORTS     (NR_WB_PORTS),
    .NR_COMMIT_PORTS (NR_COMMIT_PORTS)
  ) i_sb_entry_store (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .flush_i               (flush_i),
    .flush_unissued_i      (flush_unissued_i),
    .unresolved_branch_i   (unresolved_branch_i),
    .decoded_instr_i       (decoded_instr_i),
    .decoded_instr_valid_i (decoded_instr_valid_i),
    .issue_ack_i           (issue_ack_i),
    .wb_i                  (wb_i),
    .commit_ack_i          (commit_ack_i),
    .issue_instr_o         (issue_instr_o),
    .issue_instr_valid_o   (issue_instr_valid_o),
    .decoded_instr_ack_o   (decoded_instr_ack_o),
    .sb_full_o             (sb_full_o),
    .commit_instr_o        (commit_instr_o),
    .slots_o               (slots)
  );

  // destination registers still in flight
  sb_clobber_map i_sb_clobber_map (
    .slots_i      (slots),
    .rd_clobber_o (rd_clobber_o)
  );

  // --------------------
  // forwarding
  // --------------------
  sb_operand_fwd #(
    .NR_WB_PORTS (NR_WB_PORTS)
  ) i_sb_operand_fwd (
    .slots_i     (slots),
    .wb_i        (wb_i),
    .rs1_i       (rs1_i),
    .rs2_i       (rs2_i),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rs1_valid_o (rs1_valid_o),
    .rs2_valid_o (rs2_valid_o)
  );

endmodule

`default_nettype wire
